// ==== project.f ====
+incdir+include
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/instr_decode.sv
hdl/thread_regfile.sv
hdl/alu_stage.sv
hdl/barrel_core.sv
sim/tb_barrel_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the barrel core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_barrel_core -f project.f

output=$(./obj_dir/Vtb_barrel_core)
echo "$output"

if grep -qx "STATUS: PASS" <<< "$output"; then
  exit 0
fi
exit 1

// ==== include/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Instruction groups, used to name a failing check
localparam logic [2:0] KIND_OP_IMM = 3'd0;
localparam logic [2:0] KIND_OP     = 3'd1;
localparam logic [2:0] KIND_LUI    = 3'd2;
localparam logic [2:0] KIND_AUIPC  = 3'd3;
localparam logic [2:0] KIND_NOP    = 3'd4;

// ----------------------------------------------------------------------------
// Instruction encoding from two random words
// ----------------------------------------------------------------------------
// Registers kept to x0..x7 so threads reuse results often
function automatic logic [31:0] make_instr(input logic [31:0] r1, input logic [31:0] r2);
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  f3;
  logic [11:0] imm;
  logic [6:0]  f7;
  logic [31:0] w;
  rd  = {2'b00, r1[2:0]};
  rs1 = {2'b00, r1[5:3]};
  rs2 = {2'b00, r1[8:6]};
  f3  = r1[11:9];
  imm = r2[11:0];
  f7  = 7'b0;
  case (r1[14:12])
    3'd0, 3'd1, 3'd2: begin
      // Shift immediates carry shamt plus the arithmetic bit only
      if (f3 == 3'b001) begin
        imm[11:5] = 7'b0;
      end
      if (f3 == 3'b101) begin
        imm[11:5] = r2[12] ? 7'b0100000 : 7'b0;
      end
      w = {imm, rs1, f3, rd, 7'b0010011};
    end
    3'd3, 3'd4: begin
      // SUB and SRA are the only funct7 variants
      if ((f3 == 3'b000 || f3 == 3'b101) && r2[13]) begin
        f7 = 7'b0100000;
      end
      w = {f7, rs2, rs1, f3, rd, 7'b0110011};
    end
    3'd5:    w = {r2[31:12], rd, 7'b0110111};
    3'd6:    w = {r2[31:12], rd, 7'b0010111};
    // Load or JAL, both outside the executed set
    default: w = {r2[31:12], rd, r2[13] ? 7'b0000011 : 7'b1101111};
  endcase
  return w;
endfunction

function automatic logic [2:0] kind_of(input logic [31:0] w);
  logic [2:0] k;
  case (w[6:0])
    7'b0010011: k = KIND_OP_IMM;
    7'b0110011: k = KIND_OP;
    7'b0110111: k = KIND_LUI;
    7'b0010111: k = KIND_AUIPC;
    default:    k = KIND_NOP;
  endcase
  return k;
endfunction

function automatic string kind_name(input logic [2:0] kind);
  string s;
  case (kind)
    KIND_OP_IMM: s = "OP-IMM result";
    KIND_OP:     s = "OP result";
    KIND_LUI:    s = "LUI result";
    KIND_AUIPC:  s = "AUIPC result";
    default:     s = "no-op";
  endcase
  return s;
endfunction

// ----------------------------------------------------------------------------
// RV32I integer semantics
// ----------------------------------------------------------------------------
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic is_reg, input logic [31:0] x,
                                        input logic [31:0] y);
  logic [31:0] r;
  case (f3)
    3'b000: begin
      // Register form only has SUB
      if (is_reg && alt) begin
        r = x - y;
      end else begin
        r = x + y;
      end
    end
    3'b001: r = x << y[4:0];
    3'b010: r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
    3'b011: r = (x < y) ? 32'd1 : 32'd0;
    3'b100: r = x ^ y;
    3'b101: begin
      if (alt) begin
        r = $signed(x) >>> y[4:0];
      end else begin
        r = x >> y[4:0];
      end
    end
    3'b110: r = x | y;
    default: r = x & y;
  endcase
  return r;
endfunction

// a and b are the model's rs1 and rs2 values
function automatic logic [31:0] ref_result(input logic [31:0] w, input logic [31:0] pc,
                                           input logic [31:0] a, input logic [31:0] b);
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  logic [31:0] y;
  imm_i = {{20{w[31]}}, w[31:20]};
  imm_u = {w[31:12], 12'b0};
  case (w[6:0])
    7'b0010011: y = alu_ref(w[14:12], w[30], 1'b0, a, imm_i);
    7'b0110011: y = alu_ref(w[14:12], w[30], 1'b1, a, b);
    7'b0110111: y = imm_u;
    7'b0010111: y = pc + imm_u;
    default:    y = 32'h0;
  endcase
  return y;
endfunction

`endif

// ==== sim/tb_barrel_core.sv ====
`timescale 1ns/1ps

module tb_barrel_core;

  localparam int NT             = 5;
  localparam int AW             = 10;
  localparam int TW             = $clog2(NT);
  localparam int PROG_LEN       = 40;
  localparam int WB_LATENCY     = 4;
  localparam int TIMEOUT_CYCLES = PROG_LEN * NT + 20;

  `include "tb_ref_model.svh"

  // One expected write-back
  typedef struct packed {
    logic [2:0]  kind;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] cycle;
  } exp_t;

  logic            clk;
  logic            reset;
  core_pkg::word_t i_instr;
  logic [AW-1:0]   o_fetch_addr;
  logic [TW-1:0]   o_fetch_thread;
  logic            o_fetch_valid;
  core_pkg::wb_t   o_wb;
  logic [TW-1:0]   o_wb_thread;

  integer      seed;
  logic [31:0] prog [NT][PROG_LEN];
  logic [31:0] model_regs [NT][32];
  logic [31:0] model_pc [NT];
  exp_t        exp_q [NT][$];
  exp_t        exp_cur;
  logic        have_exp = 1'b0;
  logic [31:0] next_word = 32'h0;

  // Fetch slot expected this cycle
  logic exp_fetch_valid = 1'b0;
  int   exp_thread = 0;
  int   exp_addr = 0;
  // Expected fetch slots of recent cycles
  // Index 0 is this cycle
  logic hist_valid [WB_LATENCY+1];
  int   hist_thread [WB_LATENCY+1];

  int   cyc = 0;
  int   fetch_count = 0;
  int   wb_count = 0;
  int   pending = 0;
  int   errors = 0;
  logic run_done = 1'b0;

  barrel_core #(
    .NUM_THREADS    (NT),
    .IMEM_ADDR_WIDTH(AW)
  ) uut (
    .clk           (clk),
    .reset         (reset),
    .i_instr       (i_instr),
    .o_fetch_addr  (o_fetch_addr),
    .o_fetch_thread(o_fetch_thread),
    .o_fetch_valid (o_fetch_valid),
    .o_wb          (o_wb),
    .o_wb_thread   (o_wb_thread)
  );

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    errors++;
    $display("Error: %s expected 0x%08h actual 0x%08h at %0t", name, expected, actual, $time);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Failure at %0t: %s", $time, what);
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Cycles since reset fell
  always @(posedge clk) begin
    if (reset) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // --------------------------------------------------------------------------
  // ROM model and reference model at the falling edge
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    int   t;
    int   wt;
    logic [31:0] w;
    exp_t e;
    // ROM answers the previous cycle's fetch
    i_instr   = next_word;
    next_word = 32'h0;
    exp_fetch_valid = !reset && (cyc >= 2);
    exp_thread      = exp_fetch_valid ? (cyc - 2) % NT : 0;
    exp_addr        = exp_fetch_valid ? (cyc - 2) / NT : 0;
    for (int k = WB_LATENCY; k > 0; k--) begin
      hist_valid[k]  = hist_valid[k-1];
      hist_thread[k] = hist_thread[k-1];
    end
    hist_valid[0]  = exp_fetch_valid;
    hist_thread[0] = exp_thread;
    if (!reset && o_fetch_valid && int'(o_fetch_thread) < NT) begin
      t = int'(o_fetch_thread);
      // Past the program end the ROM holds zero (unsupported opcode)
      w = (int'(o_fetch_addr) < PROG_LEN) ? prog[t][int'(o_fetch_addr)] : 32'h0;
      next_word = w;
      fetch_count++;
      if (kind_of(w) != KIND_NOP && w[11:7] != 5'd0) begin
        e.kind  = kind_of(w);
        e.rd    = w[11:7];
        e.data  = ref_result(w, model_pc[t], model_regs[t][w[19:15]], model_regs[t][w[24:20]]);
        e.cycle = 32'(cyc);
        model_regs[t][e.rd] = e.data;
        exp_q[t].push_back(e);
      end
      model_pc[t] = model_pc[t] + 32'd4;
    end
    // Match this cycle's strobe against its thread's queue
    have_exp = 1'b0;
    if (!reset && o_wb.valid) begin
      wb_count++;
      wt = int'(o_wb_thread);
      if (wt < NT && exp_q[wt].size() > 0) begin
        exp_cur  = exp_q[wt].pop_front();
        have_exp = 1'b1;
      end
    end
    pending = 0;
    for (int k = 0; k < NT; k++) begin
      pending += exp_q[k].size();
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  a_fetch_valid : assert property (@(posedge clk) disable iff (reset)
    o_fetch_valid == exp_fetch_valid)
    else report_value("fetch valid", 32'(exp_fetch_valid), 32'($sampled(o_fetch_valid)));

  a_fetch_thread : assert property (@(posedge clk) disable iff (reset)
    o_fetch_valid |-> int'(o_fetch_thread) == exp_thread)
    else report_value("fetch thread", 32'(exp_thread), 32'($sampled(o_fetch_thread)));

  a_fetch_addr : assert property (@(posedge clk) disable iff (reset)
    o_fetch_valid |-> int'(o_fetch_addr) == exp_addr)
    else report_value("fetch address", 32'(exp_addr), 32'($sampled(o_fetch_addr)));

  // Catches x0 writes, no-op writes and extra strobes
  a_wb_expected : assert property (@(posedge clk) disable iff (reset)
    o_wb.valid |-> have_exp)
    else report_failure("write-back strobe with no pending instruction for its thread");

  a_wb_x0 : assert property (@(posedge clk) disable iff (reset)
    o_wb.valid |-> o_wb.rd != 5'd0)
    else report_failure("write-back strobe targets register x0");

  a_wb_rd : assert property (@(posedge clk) disable iff (reset)
    (o_wb.valid && have_exp) |-> o_wb.rd == exp_cur.rd)
    else report_value({kind_name(exp_cur.kind), " rd"}, 32'(exp_cur.rd),
                      32'($sampled(o_wb.rd)));

  a_wb_data : assert property (@(posedge clk) disable iff (reset)
    (o_wb.valid && have_exp) |-> o_wb.data == exp_cur.data)
    else report_value(kind_name(exp_cur.kind), exp_cur.data, $sampled(o_wb.data));

  a_wb_latency : assert property (@(posedge clk) disable iff (reset)
    (o_wb.valid && have_exp) |-> cyc == int'(exp_cur.cycle) + WB_LATENCY)
    else report_value("write-back latency", exp_cur.cycle + 32'(WB_LATENCY),
                      32'($sampled(cyc)));

  // Same thread as the fetch four cycles back
  a_wb_thread : assert property (@(posedge clk) disable iff (reset)
    o_wb.valid |-> hist_valid[WB_LATENCY] && int'(o_wb_thread) == hist_thread[WB_LATENCY])
    else report_value("write-back thread", 32'(hist_thread[WB_LATENCY]),
                      32'($sampled(o_wb_thread)));

  a_all_consumed : assert property (@(posedge clk) disable iff (reset)
    run_done |-> pending == 0)
    else report_value("pending expectations", 32'd0, 32'(pending));

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] r1;
    logic [31:0] r2;
    reset   = 1'b1;
    i_instr = 32'h0;
    seed    = 32'h1a1e_bd0e;
    for (int k = 0; k <= WB_LATENCY; k++) begin
      hist_valid[k]  = 1'b0;
      hist_thread[k] = 0;
    end
    for (int t = 0; t < NT; t++) begin
      model_pc[t] = 32'h0;
      for (int r = 0; r < 32; r++) begin
        model_regs[t][r] = 32'h0;
      end
      for (int i = 0; i < PROG_LEN; i++) begin
        r1 = $random(seed);
        r2 = $random(seed);
        prog[t][i] = make_instr(r1, r2);
      end
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // Drain the pipeline after the last program word
    wait (fetch_count >= PROG_LEN * NT);
    repeat (WB_LATENCY + 1) @(negedge clk);
    run_done = 1'b1;
    @(posedge clk);
    @(negedge clk);
    $display("Run complete: %0d fetches, %0d write-backs, %0d errors",
             fetch_count, wb_count, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (reset === 1'b0);
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles after reset", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== hdl/barrel_core.sv ====
`timescale 1ns/1ps

module barrel_core #(
  parameter int NUM_THREADS     = 8,
  parameter int IMEM_ADDR_WIDTH = 10
) (
  input  logic                           clk,
  input  logic                           reset,
  input  core_pkg::word_t                i_instr,
  output logic [IMEM_ADDR_WIDTH-1:0]     o_fetch_addr,
  output logic [$clog2(NUM_THREADS)-1:0] o_fetch_thread,
  output logic                           o_fetch_valid,
  output core_pkg::wb_t                  o_wb,
  output logic [$clog2(NUM_THREADS)-1:0] o_wb_thread
);

  localparam int TW = $clog2(NUM_THREADS);

  // Fewer threads would need forwarding
  if (NUM_THREADS < 4) begin : g_thread_check
    $error("barrel_core needs at least 4 threads");
  end

  core_pkg::fetch_t issue;
  logic [TW-1:0]    issue_thread;
  core_pkg::ctrl_t  ctrl;
  logic [TW-1:0]    ctrl_thread;
  core_pkg::word_t  rs1_data;
  core_pkg::word_t  rs2_data;

  // --------------------------------------------------------------------------
  // F1, F2
  // --------------------------------------------------------------------------
  fetch_unit #(
    .NUM_THREADS    (NUM_THREADS),
    .IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH)
  ) u_fetch (
    .clk           (clk),
    .reset         (reset),
    .i_instr       (i_instr),
    .o_fetch_addr  (o_fetch_addr),
    .o_fetch_thread(o_fetch_thread),
    .o_fetch_valid (o_fetch_valid),
    .o_issue       (issue),
    .o_issue_thread(issue_thread)
  );

  // --------------------------------------------------------------------------
  // D: decode and register read side by side
  // --------------------------------------------------------------------------
  instr_decode u_decode (
    .clk    (clk),
    .reset  (reset),
    .i_issue(issue),
    .o_ctrl (ctrl)
  );

  thread_regfile #(
    .NUM_THREADS(NUM_THREADS)
  ) u_regfile (
    .clk           (clk),
    .i_issue       (issue),
    .i_issue_thread(issue_thread),
    .i_wb          (o_wb),
    .i_wb_thread   (o_wb_thread),
    .o_rs1_data    (rs1_data),
    .o_rs2_data    (rs2_data)
  );

  // Thread index into X
  always_ff @(posedge clk) begin
    ctrl_thread <= issue_thread;
  end

  // --------------------------------------------------------------------------
  // X, W
  // --------------------------------------------------------------------------
  alu_stage #(
    .NUM_THREADS(NUM_THREADS)
  ) u_alu (
    .clk          (clk),
    .reset        (reset),
    .i_ctrl       (ctrl),
    .i_ctrl_thread(ctrl_thread),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .o_wb         (o_wb),
    .o_wb_thread  (o_wb_thread)
  );

endmodule

// ==== hdl/alu_stage.sv ====
`timescale 1ns/1ps

module alu_stage #(
  parameter int NUM_THREADS = 8
) (
  input  logic                           clk,
  input  logic                           reset,
  input  core_pkg::ctrl_t                i_ctrl,
  input  logic [$clog2(NUM_THREADS)-1:0] i_ctrl_thread,
  input  core_pkg::word_t                i_rs1_data,
  input  core_pkg::word_t                i_rs2_data,
  output core_pkg::wb_t                  o_wb,
  output logic [$clog2(NUM_THREADS)-1:0] o_wb_thread
);

  core_pkg::word_t op1;
  core_pkg::word_t op2;
  core_pkg::word_t result;
  logic [4:0]      shamt;

  // --------------------------------------------------------------------------
  // X stage operand muxes
  // --------------------------------------------------------------------------
  // PC only for AUIPC
  assign op1   = i_ctrl.op1_is_pc  ? i_ctrl.pc  : i_rs1_data;
  assign op2   = i_ctrl.op2_is_imm ? i_ctrl.imm : i_rs2_data;
  // Shift amount from low 5 bits
  assign shamt = op2[4:0];

  // Single-cycle ALU
  always_comb begin
    case (i_ctrl.alu_op)
      isa_pkg::ALU_ADD:    result = op1 + op2;
      isa_pkg::ALU_SUB:    result = op1 - op2;
      isa_pkg::ALU_SLL:    result = op1 << shamt;
      isa_pkg::ALU_SLT:    result = {{(core_pkg::XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
      isa_pkg::ALU_SLTU:   result = {{(core_pkg::XLEN-1){1'b0}}, op1 < op2};
      isa_pkg::ALU_XOR:    result = op1 ^ op2;
      isa_pkg::ALU_SRL:    result = op1 >> shamt;
      isa_pkg::ALU_SRA:    result = $signed(op1) >>> shamt;
      isa_pkg::ALU_OR:     result = op1 | op2;
      isa_pkg::ALU_AND:    result = op1 & op2;
      // LUI immediate straight through
      isa_pkg::ALU_PASS_B: result = op2;
      default:             result = op2;
    endcase
  end

  // --------------------------------------------------------------------------
  // W stage write-back record
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    o_wb.valid  <= i_ctrl.valid && i_ctrl.wr_en;
    o_wb.rd     <= i_ctrl.rd;
    o_wb.data   <= result;
    o_wb_thread <= i_ctrl_thread;
    if (reset) begin
      o_wb.valid <= 1'b0;
    end
  end

  // A write-back strobe never targets x0
  a_wb_no_x0 : assert property (
    @(posedge clk) disable iff (reset)
    o_wb.valid |-> (o_wb.rd != '0)
  );

endmodule

// ==== hdl/thread_regfile.sv ====
`timescale 1ns/1ps

module thread_regfile #(
  parameter int NUM_THREADS = 8
) (
  input  logic                           clk,
  input  core_pkg::fetch_t               i_issue,
  input  logic [$clog2(NUM_THREADS)-1:0] i_issue_thread,
  input  core_pkg::wb_t                  i_wb,
  input  logic [$clog2(NUM_THREADS)-1:0] i_wb_thread,
  output core_pkg::word_t                o_rs1_data,
  output core_pkg::word_t                o_rs2_data
);

  // One 32-entry bank per thread
  core_pkg::word_t     regs [NUM_THREADS][32];
  core_pkg::reg_addr_t rs1;
  core_pkg::reg_addr_t rs2;

  // Registers start at zero, as on the FPGA target
  initial begin
    for (int t = 0; t < NUM_THREADS; t++) begin
      for (int r = 0; r < 32; r++) begin
        regs[t][r] = '0;
      end
    end
  end

  // Source fields through the R view
  assign rs1 = i_issue.instr.r.rs1;
  assign rs2 = i_issue.instr.r.rs2;

  // --------------------------------------------------------------------------
  // D: registered reads, x0 reads as zero
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (i_issue.valid) begin
      o_rs1_data <= (rs1 == '0) ? '0 : regs[i_issue_thread][rs1];
      o_rs2_data <= (rs2 == '0) ? '0 : regs[i_issue_thread][rs2];
    end
  end

  // W: write at the end of the strobe cycle
  always_ff @(posedge clk) begin
    if (i_wb.valid) begin
      regs[i_wb_thread][i_wb.rd] <= i_wb.data;
    end
  end

  // x0 stays zero in every bank
  a_no_x0_write : assert property (
    @(posedge clk) i_wb.valid |-> (i_wb.rd != '0)
  );

endmodule

// ==== hdl/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
  input  logic             clk,
  input  logic             reset,
  input  core_pkg::fetch_t i_issue,
  output core_pkg::ctrl_t  o_ctrl
);

  core_pkg::ctrl_t ctrl_d;
  logic            supported;

  // --------------------------------------------------------------------------
  // funct3/funct7 to ALU operation
  // --------------------------------------------------------------------------
  // alt is funct7[5], which is imm[10] under OP-IMM
  function automatic isa_pkg::alu_op_e map_alu_op(
    input logic [2:0] f3,
    input logic       alt,
    input logic       is_reg
  );
    isa_pkg::alu_op_e op;
    case (f3)
      // SUB only exists in register form
      isa_pkg::F3_ADD:  op = (alt && is_reg) ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
      isa_pkg::F3_SLL:  op = isa_pkg::ALU_SLL;
      isa_pkg::F3_SLT:  op = isa_pkg::ALU_SLT;
      isa_pkg::F3_SLTU: op = isa_pkg::ALU_SLTU;
      isa_pkg::F3_XOR:  op = isa_pkg::ALU_XOR;
      // Arithmetic shift in both forms
      isa_pkg::F3_SR:   op = alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
      isa_pkg::F3_OR:   op = isa_pkg::ALU_OR;
      isa_pkg::F3_AND:  op = isa_pkg::ALU_AND;
      default:          op = isa_pkg::ALU_ADD;
    endcase
    return op;
  endfunction

  // --------------------------------------------------------------------------
  // D: opcode selects the format view
  // --------------------------------------------------------------------------
  always_comb begin
    ctrl_d            = '0;
    ctrl_d.valid      = i_issue.valid;
    ctrl_d.pc         = i_issue.pc;
    // rd sits at the same place in every view
    ctrl_d.rd         = i_issue.instr.r.rd;
    ctrl_d.alu_op     = isa_pkg::ALU_ADD;
    ctrl_d.op1_is_pc  = 1'b0;
    ctrl_d.op2_is_imm = 1'b0;
    supported         = 1'b0;

    case (i_issue.instr.r.opcode)
      isa_pkg::OPC_OP: begin
        supported     = 1'b1;
        ctrl_d.alu_op = map_alu_op(i_issue.instr.r.funct3,
                                   i_issue.instr.r.funct7[5], 1'b1);
      end
      isa_pkg::OPC_OP_IMM: begin
        supported         = 1'b1;
        ctrl_d.op2_is_imm = 1'b1;
        // Sign-extended I immediate
        ctrl_d.imm        = {{20{i_issue.instr.i.imm[11]}}, i_issue.instr.i.imm};
        ctrl_d.alu_op     = map_alu_op(i_issue.instr.i.funct3,
                                       i_issue.instr.r.funct7[5], 1'b0);
      end
      isa_pkg::OPC_LUI: begin
        supported         = 1'b1;
        ctrl_d.op2_is_imm = 1'b1;
        ctrl_d.imm        = {i_issue.instr.u.imm, 12'b0};
        ctrl_d.alu_op     = isa_pkg::ALU_PASS_B;
      end
      isa_pkg::OPC_AUIPC: begin
        supported         = 1'b1;
        ctrl_d.op1_is_pc  = 1'b1;
        ctrl_d.op2_is_imm = 1'b1;
        ctrl_d.imm        = {i_issue.instr.u.imm, 12'b0};
        ctrl_d.alu_op     = isa_pkg::ALU_ADD;
      end
      default: begin
        // Everything else is a no-op
        supported = 1'b0;
      end
    endcase

    // No write for x0 or unsupported opcodes
    ctrl_d.wr_en = supported && (i_issue.instr.r.rd != '0);
  end

  // Registered into X
  always_ff @(posedge clk) begin
    o_ctrl <= ctrl_d;
    if (reset) begin
      o_ctrl.valid <= 1'b0;
      o_ctrl.wr_en <= 1'b0;
    end
  end

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
  parameter int NUM_THREADS     = 8,
  parameter int IMEM_ADDR_WIDTH = 10
) (
  input  logic                           clk,
  input  logic                           reset,
  input  core_pkg::word_t                i_instr,
  output logic [IMEM_ADDR_WIDTH-1:0]     o_fetch_addr,
  output logic [$clog2(NUM_THREADS)-1:0] o_fetch_thread,
  output logic                           o_fetch_valid,
  output core_pkg::fetch_t               o_issue,
  output logic [$clog2(NUM_THREADS)-1:0] o_issue_thread
);

  localparam int TW = $clog2(NUM_THREADS);

  // Two-flop start delay after reset
  logic start;
  logic start_reg;

  logic [TW-1:0]   thread_cnt;
  core_pkg::word_t pc_table [NUM_THREADS];
  core_pkg::word_t cur_pc;

  // F1 to F2 carry
  logic            f1_valid;
  logic [TW-1:0]   f1_thread;
  core_pkg::word_t f1_pc;

  // --------------------------------------------------------------------------
  // F1 thread rotation and PC table
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      start     <= 1'b0;
      start_reg <= 1'b0;
    end else begin
      start     <= 1'b1;
      start_reg <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      thread_cnt <= '0;
    end else if (start_reg) begin
      // Wrap at the last thread
      thread_cnt <= (int'(thread_cnt) == NUM_THREADS - 1) ? '0 : thread_cnt + 1'b1;
    end
  end

  // Word address of the issuing thread
  assign cur_pc         = pc_table[thread_cnt];
  assign o_fetch_addr   = cur_pc[IMEM_ADDR_WIDTH+1:2];
  assign o_fetch_thread = thread_cnt;
  assign o_fetch_valid  = start_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int t = 0; t < NUM_THREADS; t++) begin
        pc_table[t] <= '0;
      end
    end else if (start_reg) begin
      // Straight-line flow only
      pc_table[thread_cnt] <= cur_pc + 32'd4;
    end
  end

  // --------------------------------------------------------------------------
  // F2 capture of the ROM word into the issue record
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    f1_thread <= thread_cnt;
    f1_pc     <= cur_pc;
    f1_valid  <= start_reg;
    if (reset) begin
      f1_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    o_issue.valid  <= f1_valid;
    o_issue.pc     <= f1_pc;
    o_issue.instr  <= i_instr;
    o_issue_thread <= f1_thread;
    if (reset) begin
      o_issue.valid <= 1'b0;
    end
  end

  // Counter never leaves the thread range
  a_thread_range : assert property (
    @(posedge clk) disable iff (reset) int'(thread_cnt) < NUM_THREADS
  );

endmodule

// ==== hdl/core_pkg.sv ====
package core_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // --------------------------------------------------------------------------
  // Stage records
  // --------------------------------------------------------------------------

  // Fetch to D, 65 bits
  typedef struct packed {
    logic            valid;
    word_t           pc;
    isa_pkg::instr_u instr;
  } fetch_t;

  // D to X
  typedef struct packed {
    logic             valid;
    isa_pkg::alu_op_e alu_op;
    // Operand 1 from PC instead of rs1
    logic             op1_is_pc;
    // Operand 2 from immediate instead of rs2
    logic             op2_is_imm;
    word_t            imm;
    word_t            pc;
    reg_addr_t        rd;
    logic             wr_en;
  } ctrl_t;

  // X to W, 38 bits
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     data;
  } wb_t;

endpackage

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

  // --------------------------------------------------------------------------
  // Major opcodes executed by the core
  // --------------------------------------------------------------------------
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcode_e;

  // funct3 codes shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // --------------------------------------------------------------------------
  // ALU operations
  // --------------------------------------------------------------------------
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    // Operand 2 straight through, for LUI
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // --------------------------------------------------------------------------
  // Instruction layouts, MSB first
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // One fetched word, viewed per format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
  } instr_u;

endpackage
